//--- build.f
+incdir+hdl
hdl/mdll_frac_pkg.sv
hdl/mdll_sdm1_multibit.sv
hdl/mdll_dither_lfsr.sv
hdl/mdll_update_timer.sv
hdl/mdll_frac_ctrl_fsm.sv
hdl/mdll_div_code_gen.sv
hdl/mdll_frac_top.sv
testbench/mdll_frac_tb.sv

//--- hdl/mdll_dither_lfsr.sv
// ----------------------------------------
// lfsr dither source
// ----------------------------------------

`timescale 1ns/1ps

`include "mdll_frac_macros.svh"

module mdll_dither_lfsr import mdll_frac_pkg::*; #(
	parameter int N_DI = `MDLL_N_DI // dither width
) (
	input logic clk,
	input logic rstn,
	input logic tick, // step once per update
	input logic dith_en,
	output dither_t dither // -2 .. +1, or 0 when off
);

	logic [15:0] lfsr_q;
	logic fb;

	// x^16 + x^15 + x^13 + x^4 + 1, maximal length
	assign fb = lfsr_q[15] ^ lfsr_q[14] ^ lfsr_q[12] ^ lfsr_q[3];

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			lfsr_q <= `MDLL_LFSR_SEED;
		else if (tick)
			lfsr_q <= {lfsr_q[14:0], fb}; // fibonacci shift
	end

	// low two bits sign extended
	assign dither = dith_en ? {{(N_DI-2){lfsr_q[1]}}, lfsr_q[1:0]} : '0;

	// all-zero state is a lockup
	a_lfsr_nonzero: assert property (@(posedge clk) disable iff (!rstn)
		lfsr_q != '0)
		else $error("lfsr stuck at zero");

endmodule

//--- hdl/mdll_div_code_gen.sv
// ----------------------------------------
// divide word generator
// ----------------------------------------

`timescale 1ns/1ps

module mdll_div_code_gen import mdll_frac_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic tick, // issue point
	input logic running, // from fsm, gates issue
	input int_ratio_t n_int,
	input sdm_code_t sdm_code,
	output div_word_t div_word
);

	div_code_t code_sum; // ratio plus code
	div_code_t code_q;
	logic valid_q;
	logic issue;

	assign issue = tick && running;
	assign code_sum = div_code_t'(n_int) + div_code_t'(sdm_code); // carry in msb

	// valid strobe, control
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			valid_q <= 1'b0;
		else
			valid_q <= issue; // high one cycle after the tick
	end

	// payload holds between words
	always_ff @(posedge clk) begin
		if (issue)
			code_q <= code_sum;
	end

	assign div_word.code = code_q;
	assign div_word.valid = valid_q;

endmodule

//--- hdl/mdll_frac_ctrl_fsm.sv
// ----------------------------------------
// fractional path sequencer
// ----------------------------------------

`timescale 1ns/1ps

`include "mdll_frac_macros.svh"

module mdll_frac_ctrl_fsm import mdll_frac_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic cfg_load, // one-cycle load strobe
	input logic cfg_stop, // one-cycle stop strobe
	input logic tick,
	input mdll_cfg_t cfg,
	output mdll_cfg_t cfg_q, // config held for the datapath
	output logic tmr_restart,
	output logic sdm_clr,
	output logic sdm_en,
	output logic running, // warm-up or run
	output logic frac_active
);

	localparam int WU_W = $clog2(`MDLL_WARMUP_TICKS + 1);
	localparam logic [WU_W-1:0] WU_LAST = WU_W'(`MDLL_WARMUP_TICKS - 1);

	ctrl_state_t state, state_nxt;
	logic [WU_W-1:0] wu_cnt; // warm-up ticks seen
	logic load_q; // load seen last edge

	// ----------------------------------------
	// next state
	// ----------------------------------------
	always_comb begin
		state_nxt = state;
		if (cfg_load)
			state_nxt = ST_WARMUP; // also restarts a running sequence
		else if (cfg_stop)
			state_nxt = ST_IDLE;
		else if (state == ST_WARMUP && tick && wu_cnt == WU_LAST)
			state_nxt = ST_RUN;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= ST_IDLE;
			wu_cnt <= '0;
			load_q <= 1'b0;
			cfg_q <= '0;
		end else begin
			state <= state_nxt;
			load_q <= cfg_load; // one-cycle restart/clear pulse
			if (cfg_load) begin
				cfg_q <= cfg;
				wu_cnt <= '0;
			end else if (state == ST_WARMUP && tick) begin
				wu_cnt <= wu_cnt + 1'b1;
			end
		end
	end

	assign tmr_restart = load_q;
	assign sdm_clr = load_q;
	assign sdm_en = (state == ST_RUN);
	assign frac_active = (state == ST_RUN);
	// stop blocks a word on a coinciding tick
	assign running = (state != ST_IDLE) && !cfg_stop;

endmodule

//--- hdl/mdll_frac_macros.svh
// ----------------------------------------
// mdll fractional path constants
// ----------------------------------------

`ifndef MDLL_FRAC_MACROS_SVH
`define MDLL_FRAC_MACROS_SVH

// datapath widths
`define MDLL_N_DI 6 // fractional input width
`define MDLL_N_DO 2 // modulator output width
`define MDLL_N_INT 6 // integer divide ratio width
`define MDLL_N_TMR 8 // update timer width

// sequencing
`define MDLL_WARMUP_TICKS 4 // ticks spent in warm-up before run

// dither source
`define MDLL_LFSR_SEED 16'hace1 // any nonzero value

`endif

//--- hdl/mdll_frac_pkg.sv
// ----------------------------------------
// mdll fractional path types
// ----------------------------------------

`include "mdll_frac_macros.svh"

package mdll_frac_pkg;

	// plain vectors with a meaning
	typedef logic [`MDLL_N_DI-1:0] frac_t; // fractional code
	typedef logic [`MDLL_N_DO-1:0] sdm_code_t; // modulator output code
	typedef logic signed [`MDLL_N_DI-1:0] dither_t; // signed dither
	typedef logic [`MDLL_N_INT-1:0] int_ratio_t; // integer ratio
	typedef logic [`MDLL_N_INT:0] div_code_t; // ratio plus code, one carry bit
	typedef logic [`MDLL_N_TMR-1:0] tmr_t; // timer count

	// configuration word, 21 bits
	typedef struct packed {
		int_ratio_t n_int; // integer divide ratio
		frac_t n_frac; // fraction, lsb = 1/64
		tmr_t upd_period; // clk cycles per update
		logic dith_en; // add lfsr dither
	} mdll_cfg_t;

	// divide word to the divider, 8 bits
	typedef struct packed {
		div_code_t code;
		logic valid; // one-cycle strobe, no ready
	} div_word_t;

	// control fsm
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_WARMUP = 2'd1,
		ST_RUN = 2'd2
	} ctrl_state_t;

endpackage

//--- hdl/mdll_frac_top.sv
// ----------------------------------------
// mdll fractional control path
// ----------------------------------------

`timescale 1ns/1ps

`include "mdll_frac_macros.svh"

module mdll_frac_top import mdll_frac_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic cfg_load,
	input logic cfg_stop,
	input mdll_cfg_t cfg,
	output div_word_t div_word,
	output logic frac_active
);

	mdll_cfg_t cfg_q; // held config
	logic tmr_restart;
	logic sdm_clr;
	logic sdm_en;
	logic running;
	logic tick; // update strobe, shared
	dither_t dither;
	sdm_code_t sdm_code;

	// ----------------------------------------
	// sequencing
	// ----------------------------------------
	mdll_frac_ctrl_fsm mdll_frac_ctrl_fsm_i (
		.clk (clk),
		.rstn (rstn),
		.cfg_load (cfg_load),
		.cfg_stop (cfg_stop),
		.tick (tick),
		.cfg (cfg),
		.cfg_q (cfg_q),
		.tmr_restart (tmr_restart),
		.sdm_clr (sdm_clr),
		.sdm_en (sdm_en),
		.running (running),
		.frac_active (frac_active)
	);

	mdll_update_timer mdll_update_timer_i (
		.clk (clk),
		.rstn (rstn),
		.restart (tmr_restart),
		.period (cfg_q.upd_period),
		.tick (tick)
	);

	// ----------------------------------------
	// datapath
	// ----------------------------------------
	mdll_dither_lfsr #(.N_DI(`MDLL_N_DI)) mdll_dither_lfsr_i (
		.clk (clk),
		.rstn (rstn),
		.tick (tick),
		.dith_en (cfg_q.dith_en),
		.dither (dither)
	);

	mdll_sdm1_multibit #(.N_DI(`MDLL_N_DI), .N_DO(`MDLL_N_DO)) mdll_sdm1_multibit_i (
		.clk (clk),
		.rstn (rstn),
		.en_sdm (sdm_en),
		.clr (sdm_clr),
		.tick (tick),
		.din (cfg_q.n_frac),
		.dither (dither),
		.dout (sdm_code)
	);

	mdll_div_code_gen mdll_div_code_gen_i (
		.clk (clk),
		.rstn (rstn),
		.tick (tick),
		.running (running),
		.n_int (cfg_q.n_int),
		.sdm_code (sdm_code),
		.div_word (div_word)
	);

endmodule

//--- hdl/mdll_sdm1_multibit.sv
// ----------------------------------------
// first-order multibit sigma-delta
// ----------------------------------------

`timescale 1ns/1ps

`include "mdll_frac_macros.svh"

module mdll_sdm1_multibit import mdll_frac_pkg::*; #(
	parameter int N_DI = `MDLL_N_DI, // input width
	parameter int N_DO = `MDLL_N_DO // output width
) (
	input logic clk,
	input logic rstn,
	input logic en_sdm, // run the loop, else output forced to 0
	input logic clr, // sync clear of loop state
	input logic tick, // update strobe
	input frac_t din, // fractional part
	input dither_t dither, // signed dither, zero when off
	output sdm_code_t dout
);

	// ----------------------------------------
	// loop signals
	// ----------------------------------------
	localparam int MODULO = N_DI - N_DO; // 2**MODULO is one code step
	localparam int QW = N_DI + 2; // headroom for residue and dither

	logic signed [QW-1:0] qin; // quantizer input, unsaturated
	logic signed [QW-1:0] qin_d; // qin one update back
	logic [N_DI-1:0] dac_d; // dac value one update back
	logic [N_DI-1:0] qsat; // quantizer input after saturation
	logic [N_DO-1:0] qcode; // quantizer output

	// residue is qin_d - dac_d, folded into the sum
	assign qin = $signed({2'b00, din}) + qin_d - $signed({2'b00, dac_d})
		+ $signed({{2{dither[N_DI-1]}}, dither});

	// clamp to 0 .. 2**N_DI-1
	always_comb begin
		if (qin[QW-1])
			qsat = '0; // negative
		else if (|qin[QW-2:N_DI])
			qsat = '1; // above full scale
		else
			qsat = qin[N_DI-1:0];
	end

	assign qcode = qsat[N_DI-1 -: N_DO]; // top bits, i.e. >> MODULO
	assign dout = en_sdm ? qcode : '0;

	// ----------------------------------------
	// loop state, advances on enabled ticks
	// ----------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			qin_d <= '0;
			dac_d <= '0;
		end else if (clr) begin
			qin_d <= '0;
			dac_d <= '0;
		end else if (tick && en_sdm) begin
			qin_d <= qin; // unsaturated, keeps the error
			dac_d <= {qcode, {MODULO{1'b0}}}; // code << MODULO
		end
	end

	// divide word must carry the bare ratio outside run
	a_dout_zero_off: assert property (@(posedge clk) disable iff (!rstn)
		!en_sdm |-> dout == '0)
		else $error("sdm code nonzero while disabled");

endmodule

//--- hdl/mdll_update_timer.sv
// ----------------------------------------
// update tick timer
// ----------------------------------------

`timescale 1ns/1ps

module mdll_update_timer import mdll_frac_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic restart, // reload, from the fsm
	input tmr_t period, // cycles between ticks
	output logic tick
);

	tmr_t cnt; // down counter
	logic armed; // set by the first restart

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cnt <= '0;
			armed <= 1'b0;
		end else if (restart) begin
			cnt <= period - 1'b1;
			armed <= 1'b1;
		end else if (armed) begin
			if (cnt == '0)
				cnt <= period - 1'b1; // terminal count, wrap
			else
				cnt <= cnt - 1'b1;
		end
	end

	// one cycle at terminal count, none on the restart cycle
	assign tick = armed && !restart && (cnt == '0);

	a_period_min: assert property (@(posedge clk) disable iff (!rstn)
		restart |-> period >= 2)
		else $error("update period below 2");

endmodule

//--- run_sim.sh
#!/bin/sh
# compile with Verilator and run the testbench
# exit status is nonzero unless the pass message shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f build.f --top-module mdll_frac_tb \
	&& ./obj_dir/Vmdll_frac_tb | tee /dev/stderr | grep "TB PASSED" > /dev/null \
	&& echo "simulation ok" \
	|| { echo "simulation failed"; exit 1; }

//--- testbench/mdll_frac_tb.sv
// ----------------------------------------
// mdll fractional path testbench
// ----------------------------------------

`timescale 1ns/1ps

`include "mdll_frac_macros.svh"

module mdll_frac_tb import mdll_frac_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int WU = `MDLL_WARMUP_TICKS;
	localparam int MODULO = `MDLL_N_DI - `MDLL_N_DO; // code step is 2**MODULO
	localparam int FS = (1 << `MDLL_N_DI) - 1; // quantizer full scale
	localparam int INT_WORDS = 8;
	localparam int FRAC_RUNS = 4;
	localparam int FRAC_WORDS = 24;
	localparam int AVG_WORDS = 32;
	localparam int DITH_WORDS = 256;
	// ticks times periods, plus reset, idle and stop windows, times 2
	localparam int WD_CYCLES = 2 * (4 + 50 + INT_WORDS * 5 + FRAC_RUNS * (WU + FRAC_WORDS) * 3
		+ (WU + AVG_WORDS) * 2 + (WU + DITH_WORDS) * 2 + (2 * WU + 6) * 4 + 3 * 4 + 60);

	logic clk;
	logic rstn;
	logic cfg_load;
	logic cfg_stop;
	mdll_cfg_t cfg;
	div_word_t div_word;
	logic frac_active;

	int err_cnt;
	int word_cnt;
	int model_res; // residue of the reference loop
	integer seed;

	mdll_frac_top mdll_frac_top_i (
		.clk (clk),
		.rstn (rstn),
		.cfg_load (cfg_load),
		.cfg_stop (cfg_stop),
		.cfg (cfg),
		.div_word (div_word),
		.frac_active (frac_active)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	task automatic next_cycle; // lands 1 ns after the edge
		@(posedge clk);
		#1;
	endtask

	task automatic report_mismatch(input string name, input int exp, input int act);
		err_cnt++;
		$display("mismatch %s: expected %0d, actual %0d", name, exp, act);
	endtask

	task automatic load_cfg(input int n_int, input int n_frac, input int period, input bit dith);
		cfg.n_int = int_ratio_t'(n_int);
		cfg.n_frac = frac_t'(n_frac);
		cfg.upd_period = tmr_t'(period);
		cfg.dith_en = dith;
		cfg_load = 1'b1;
		next_cycle(); // load registered here
		cfg_load = 1'b0;
	endtask

	task automatic stop_run;
		cfg_stop = 1'b1;
		next_cycle();
		cfg_stop = 1'b0;
		repeat (2) next_cycle();
	endtask

	// waits for the next valid, gap counts cycles from the call
	task automatic wait_word(input string name, input int limit, output int code, output int gap);
		gap = 0;
		code = -1;
		do begin
			next_cycle();
			gap++;
		end while (!div_word.valid && gap < limit);
		if (div_word.valid) begin
			code = int'(div_word.code);
			word_cnt++;
		end else begin
			err_cnt++;
			$display("%s: no divide word within %0d cycles", name, limit);
		end
	endtask

	// one modulator update, straight from the loop rule
	task automatic model_step(input int f, input int d, output int code);
		int q;
		int qs;
		q = f + model_res + d;
		qs = (q < 0) ? 0 : (q > FS) ? FS : q; // saturate
		code = qs >> MODULO;
		model_res = q - (code << MODULO); // residue from unsaturated input
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic test_reset_state;
		repeat (50) begin
			next_cycle();
			if (div_word.valid !== 1'b0)
				report_mismatch("reset valid", 0, div_word.valid);
			if (frac_active !== 1'b0)
				report_mismatch("reset frac_active", 0, frac_active);
		end
	endtask

	task automatic test_integer_only;
		int code;
		int gap;
		stop_run();
		load_cfg(20, 0, 5, 1'b0);
		for (int k = 1; k <= INT_WORDS; k++) begin
			wait_word("integer only", 12, code, gap);
			if (code != 20)
				report_mismatch("integer code", 20, code);
			if (gap != ((k == 1) ? 6 : 5)) // first one waits for the restart
				report_mismatch("integer spacing", (k == 1) ? 6 : 5, gap);
			if (frac_active != (k >= WU)) // run starts on the 4th tick
				report_mismatch("integer frac_active", k >= WU, frac_active);
		end
	endtask

	task automatic test_frac_sequence;
		int n;
		int f;
		int code;
		int gap;
		int exp;
		for (int t = 0; t < FRAC_RUNS; t++) begin
			n = 8 + (($random(seed) & 32'h7fff_ffff) % 48);
			f = ($random(seed) & 32'h7fff_ffff) % 49; // no saturation up to 48
			if (t == FRAC_RUNS - 1)
				f = 49 + f % 3; // saturating run, residue grows by f - 48 per word
			stop_run();
			load_cfg(n, f, 3, 1'b0);
			model_res = 0;
			repeat (WU) begin
				wait_word("frac warm-up", 10, code, gap);
				if (code != n)
					report_mismatch("frac warm-up", n, code);
			end
			repeat (FRAC_WORDS) begin
				wait_word("frac run", 10, code, gap);
				model_step(f, 0, exp);
				if (code != n + exp)
					report_mismatch("frac run", n + exp, code);
			end
		end
	endtask

	task automatic test_average;
		int code;
		int gap;
		int sum;
		sum = 0;
		stop_run();
		load_cfg(17, 37, 2, 1'b0);
		repeat (WU) wait_word("average warm-up", 8, code, gap);
		repeat (AVG_WORDS) begin
			wait_word("average", 8, code, gap);
			sum += code;
		end
		if (sum != AVG_WORDS * 17 + 2 * 37)
			report_mismatch("average sum", AVG_WORDS * 17 + 2 * 37, sum);
	endtask

	task automatic test_dither;
		int code;
		int gap;
		int sum;
		int exp;
		sum = 0;
		exp = DITH_WORDS * 10 + 16 * 24; // 256 x (n_int + n_frac/16)
		stop_run();
		load_cfg(10, 24, 2, 1'b1);
		repeat (WU) wait_word("dither warm-up", 8, code, gap);
		repeat (DITH_WORDS) begin
			wait_word("dither", 8, code, gap);
			sum += code;
			if (code < 10 || code > 13) begin
				err_cnt++;
				$display("mismatch dither range: expected 10 to 13, actual %0d", code);
			end
		end
		if ((sum - exp) * 10 > DITH_WORDS || (exp - sum) * 10 > DITH_WORDS) begin
			err_cnt++;
			$display("mismatch dither mean: expected %0d/256 within 0.1, actual %0d/256", exp, sum);
		end
	endtask

	task automatic test_reload_stop;
		int code;
		int gap;
		stop_run();
		load_cfg(30, 16, 4, 1'b0);
		repeat (2 * WU) wait_word("reload first run", 12, code, gap);
		load_cfg(12, 40, 4, 1'b0); // tick is low right after a word
		if (frac_active !== 1'b0)
			report_mismatch("reload frac_active", 0, frac_active);
		repeat (WU) begin
			wait_word("reload warm-up", 12, code, gap);
			if (code != 12)
				report_mismatch("reload warm-up", 12, code);
		end
		if (frac_active !== 1'b1)
			report_mismatch("reload run entry", 1, frac_active);
		repeat (2) wait_word("reload run", 12, code, gap);
		cfg_stop = 1'b1;
		next_cycle();
		cfg_stop = 1'b0;
		repeat (3 * 4) begin
			if (div_word.valid !== 1'b0)
				report_mismatch("valid after stop", 0, div_word.valid);
			if (frac_active !== 1'b0)
				report_mismatch("frac_active after stop", 0, frac_active);
			next_cycle();
		end
	endtask

	// ----------------------------------------
	// sequence and watchdog
	// ----------------------------------------
	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		cfg_load = 1'b0;
		cfg_stop = 1'b0;
		cfg = '0;
		err_cnt = 0;
		word_cnt = 0;
		model_res = 0;
		seed = 32'h274d;
		repeat (4) @(posedge clk);
		#1;
		rstn = 1'b1;
		test_reset_state();
		test_integer_only();
		test_frac_sequence();
		test_average();
		test_dither();
		test_reload_stop();
		$display("done: 6 tests, %0d words checked, %0d errors", word_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("watchdog expired, the tests did not finish in %0d cycles", WD_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule
